// File: sim.f
+incdir+.
sensor_pkg.sv
sensor_packet_builder.sv
sensor_report_parser.sv
spi_sensor_slave.sv
sensor_hub_top.sv
tb_sensor_hub_chk.sv
tb_sensor_hub.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_sensor_hub
FILELIST  = sim.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb_sensor_hub.sv
`default_nettype none
`include "sensor_defs.svh"

// Testbench for the IMU to SPI bridge
// Packets go in on the byte link and frames come back through an SPI master model
module tb_sensor_hub;

    import sensor_pkg::*;

    logic        clk;
    logic        rst_n;
    shtp_byte_t  rx;
    logic        rx_valid;
    logic        sclk;
    logic        cs_n;
    logic        miso;
    integer      seed;
    logic [7:0]  seq_no;
    // Packet being sent, byte 0 goes out with sop
    logic [7:0]  pkt[$];
    // Bytes shifted in during the last SPI read
    logic [7:0]  got_q[$];
    // Last complete readings sent, which the frame has to show
    logic [15:0] exp_qw, exp_qx, exp_qy, exp_qz;
    logic [15:0] exp_gx, exp_gy, exp_gz;
    logic        exp_qok;
    logic        exp_gok;
    // Values of the report in flight, taken into the model once it is complete
    logic [15:0] nq_w, nq_x, nq_y, nq_z;
    logic [15:0] ng_x, ng_y, ng_z;

    sensor_hub_top uut (
        .clk      (clk),
        .rst_n    (rst_n),
        .rx       (rx),
        .rx_valid (rx_valid),
        .sclk     (sclk),
        .cs_n     (cs_n),
        .miso     (miso)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    task abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    // Advance n rising edges and land 5 units after the last one
    task step_clocks(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
        end
        #5;
    endtask

    function automatic logic [15:0] next_word();
        logic [31:0] r;
        r = $random(seed);
        return r[15:0];
    endfunction

    // Transport header, then the report header with zero status and delay
    // Length bytes are filled in when the packet goes out
    task begin_packet(input logic [7:0] channel, input logic [7:0] report_id);
        pkt.delete();
        pkt.push_back(8'h00);
        pkt.push_back(8'h00);
        pkt.push_back(channel);
        pkt.push_back(seq_no);
        pkt.push_back(report_id);
        pkt.push_back(seq_no);
        pkt.push_back(8'h00);
        pkt.push_back(8'h00);
        seq_no = seq_no + 8'd1;
    endtask

    // Values travel little-endian
    task push_word(input logic [15:0] value);
        pkt.push_back(value[7:0]);
        pkt.push_back(value[15:8]);
    endtask

    task send_range(input int first, input int last);
        int n;
        if (first == 0) begin
            n = pkt.size();
            pkt[0] = n[7:0];
            pkt[1] = n[15:8];
        end
        for (int i = first; i <= last; i++) begin
            rx       = {i == 0, pkt[i]};
            rx_valid = 1'b1;
            step_clocks(1);
        end
        rx_valid = 1'b0;
        rx       = '0;
        // Leaves well over 5 clocks between the last byte and any chip select
        step_clocks(8);
    endtask

    task new_rotation();
        nq_x = next_word();
        nq_y = next_word();
        nq_z = next_word();
        nq_w = next_word();
        begin_packet(`SHTP_CHANNEL_INPUT, `SENSOR_REPORT_ROTATION);
        push_word(nq_x);
        push_word(nq_y);
        push_word(nq_z);
        push_word(nq_w);
        // Accuracy estimate, which the bridge drops
        push_word(next_word());
    endtask

    task new_gyro();
        ng_x = next_word();
        ng_y = next_word();
        ng_z = next_word();
        begin_packet(`SHTP_CHANNEL_INPUT, `SENSOR_REPORT_GYRO);
        push_word(ng_x);
        push_word(ng_y);
        push_word(ng_z);
    endtask

    task accept_rotation();
        exp_qw  = nq_w;
        exp_qx  = nq_x;
        exp_qy  = nq_y;
        exp_qz  = nq_z;
        exp_qok = 1'b1;
    endtask

    task accept_gyro();
        exp_gx  = ng_x;
        exp_gy  = ng_y;
        exp_gz  = ng_z;
        exp_gok = 1'b1;
    endtask

    // cs_n was just raised, so miso has to drop once the slave sees it
    task wait_miso_idle();
        int n;
        n = 0;
        while (miso !== 1'b0) begin
            if (n == 8) begin
                $display("miso did not return low within 8 clocks of chip select release");
                abort_run();
            end
            step_clocks(1);
            n++;
        end
        step_clocks(4);
    endtask

    // Mode 0 master, half-period of 10 clocks, one byte past the frame
    task read_frame();
        logic [7:0] b;
        got_q.delete();
        cs_n = 1'b0;
        // Snapshot and first bit appear three clocks after select
        step_clocks(10);
        for (int k = 0; k < `SENSOR_FRAME_BYTES + 1; k++) begin
            b = 8'h00;
            for (int j = 0; j < 8; j++) begin
                sclk = 1'b1;
                b    = {b[6:0], miso};
                step_clocks(10);
                sclk = 1'b0;
                step_clocks(10);
            end
            got_q.push_back(b);
        end
        cs_n = 1'b1;
        wait_miso_idle();
    endtask

    // Mode 0 read broken off inside the status byte
    // Chip select goes away while miso still carries a status bit
    task read_cut_short(input int n_bits);
        logic [7:0] status;
        status = {6'b000000, exp_gok, exp_qok};
        cs_n = 1'b0;
        step_clocks(10);
        for (int j = 0; j < n_bits; j++) begin
            sclk = 1'b1;
            step_clocks(10);
            sclk = 1'b0;
            step_clocks(10);
        end
        // After n_bits shifts the slave shows status bit 7 - n_bits
        assert (miso === status[7 - n_bits]) else begin
            $display("error: miso after %0d bits got %h expected %h",
                     n_bits, miso, status[7 - n_bits]);
            abort_run();
        end
        cs_n = 1'b1;
        wait_miso_idle();
    endtask

    task check_frame();
        logic [127:0] exp_frame;
        // Status, quaternion w x y z, gyro x y z, then a byte of zero fill
        exp_frame = {6'b000000, exp_gok, exp_qok, exp_qw, exp_qx, exp_qy, exp_qz,
                     exp_gx, exp_gy, exp_gz, 8'h00};
        for (int i = 0; i < `SENSOR_FRAME_BYTES + 1; i++) begin
            assert (got_q[i] === exp_frame[127 - 8 * i -: 8]) else begin
                $display("error: miso byte %0d got %h expected %h",
                         i, got_q[i], exp_frame[127 - 8 * i -: 8]);
                abort_run();
            end
        end
    endtask

    initial begin
        seed     = 32'h1692_586a;
        seq_no   = 8'h00;
        rst_n    = 1'b0;
        rx       = '0;
        rx_valid = 1'b0;
        sclk     = 1'b0;
        cs_n     = 1'b1;
        {exp_qw, exp_qx, exp_qy, exp_qz} = '0;
        {exp_gx, exp_gy, exp_gz} = '0;
        exp_qok = 1'b0;
        exp_gok = 1'b0;
        step_clocks(10);
        rst_n = 1'b1;
        step_clocks(2);

        // Nothing received yet
        read_frame();
        check_frame();

        new_rotation();
        send_range(0, pkt.size() - 1);
        accept_rotation();
        read_frame();
        check_frame();

        new_gyro();
        send_range(0, pkt.size() - 1);
        accept_gyro();
        read_frame();
        check_frame();

        // Status is 0x03 now, so bit 0 is high on miso when select is released
        read_cut_short(7);

        // Bytes 0 to 11 carry both headers plus x and y of the new quaternion
        new_rotation();
        send_range(0, 11);
        read_frame();
        check_frame();
        send_range(12, pkt.size() - 1);
        accept_rotation();
        read_frame();
        check_frame();

        // Foreign channel, then an accelerometer report the bridge does not decode
        begin_packet(8'd2, `SENSOR_REPORT_ROTATION);
        repeat (4) push_word(next_word());
        send_range(0, pkt.size() - 1);
        begin_packet(`SHTP_CHANNEL_INPUT, 8'h01);
        repeat (3) push_word(next_word());
        send_range(0, pkt.size() - 1);
        read_frame();
        check_frame();

        // Gyro packet broken off after the low byte of x, then a full one with sop
        new_gyro();
        send_range(0, 8);
        new_gyro();
        send_range(0, pkt.size() - 1);
        accept_gyro();
        read_frame();
        check_frame();

        if (uut.u_chk.fail_count == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            $display("bound checker counted %0d assertion failures", uut.u_chk.fail_count);
            abort_run();
        end
    end

endmodule

`default_nettype wire

// File: tb_sensor_hub_chk.sv
`default_nettype none

// Concurrent checks on the bridge top level
// Bound into sensor_hub_top, so every port below is a signal of that module
module tb_sensor_hub_chk (
    input logic              clk,
    input logic              rst_n,
    input sensor_pkg::quat_t quat_held,
    input logic              quat_done,
    input logic              quat_ok,
    input sensor_pkg::gyro_t gyro_held,
    input logic              gyro_done,
    input logic              gyro_ok,
    input logic              cs_n,
    input logic              miso
);

    // Number of assertion failures so far
    int fail_count = 0;

    // A held reading moves only on the edge right after its done pulse
    quat_held_on_done: assert property (@(posedge clk) disable iff (!rst_n)
        !$stable(quat_held) |-> $past(quat_done))
        else begin
            fail_count = fail_count + 1;
            $error("quaternion hold register changed without a done pulse");
        end

    gyro_held_on_done: assert property (@(posedge clk) disable iff (!rst_n)
        !$stable(gyro_held) |-> $past(gyro_done))
        else begin
            fail_count = fail_count + 1;
            $error("gyro hold register changed without a done pulse");
        end

    // Valid flags are sticky until the next reset
    quat_ok_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        quat_ok |=> quat_ok)
        else begin
            fail_count = fail_count + 1;
            $error("quat_ok fell while out of reset");
        end

    gyro_ok_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        gyro_ok |=> gyro_ok)
        else begin
            fail_count = fail_count + 1;
            $error("gyro_ok fell while out of reset");
        end

    // cs_n two samples back is what the slave's two-flop synchronizer shows now
    miso_low_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
        $past(cs_n, 2) |-> !miso)
        else begin
            fail_count = fail_count + 1;
            $error("miso was high while the synchronized chip select was high");
        end

endmodule

bind sensor_hub_top tb_sensor_hub_chk u_chk (
    .clk       (clk),
    .rst_n     (rst_n),
    .quat_held (quat_held),
    .quat_done (quat_done),
    .quat_ok   (quat_ok),
    .gyro_held (gyro_held),
    .gyro_done (gyro_done),
    .gyro_ok   (gyro_ok),
    .cs_n      (cs_n),
    .miso      (miso)
);

`default_nettype wire

// File: sensor_hub_top.sv
`default_nettype none

// IMU host link to SPI bridge
// Parser decodes reports, two builders hold the last complete readings,
// and the SPI slave serves them to the microcontroller
module sensor_hub_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  sensor_pkg::shtp_byte_t rx,
    input  logic                   rx_valid,
    input  logic                   sclk,
    input  logic                   cs_n,
    output logic                   miso
);

    import sensor_pkg::*;

    // Fields straight from the parser, valid only at the done pulses
    quat_t quat_raw;
    gyro_t gyro_raw;
    logic  quat_done;
    logic  gyro_done;

    // Complete readings and their sticky flags
    quat_t quat_held;
    gyro_t gyro_held;
    logic  quat_ok;
    logic  gyro_ok;

    sensor_report_parser u_parser (
        .clk       (clk),
        .rst_n     (rst_n),
        .rx        (rx),
        .rx_valid  (rx_valid),
        .quat_raw  (quat_raw),
        .quat_done (quat_done),
        .gyro_raw  (gyro_raw),
        .gyro_done (gyro_done)
    );

    // Same holding register for both payloads, only the type differs
    sensor_packet_builder #(
        .payload_t (quat_t)
    ) u_quat_builder (
        .clk     (clk),
        .rst_n   (rst_n),
        .capture (quat_done),
        .din     (quat_raw),
        .dout    (quat_held),
        .held    (quat_ok)
    );

    sensor_packet_builder #(
        .payload_t (gyro_t)
    ) u_gyro_builder (
        .clk     (clk),
        .rst_n   (rst_n),
        .capture (gyro_done),
        .din     (gyro_raw),
        .dout    (gyro_held),
        .held    (gyro_ok)
    );

    spi_sensor_slave u_spi (
        .clk     (clk),
        .rst_n   (rst_n),
        .quat    (quat_held),
        .quat_ok (quat_ok),
        .gyro    (gyro_held),
        .gyro_ok (gyro_ok),
        .sclk    (sclk),
        .cs_n    (cs_n),
        .miso    (miso)
    );

endmodule

`default_nettype wire

// File: spi_sensor_slave.sv
`default_nettype none
`include "sensor_defs.svh"

// Read-only SPI mode-0 slave that serves the latest readings
// Frame, MSB first
//   byte 0       status: bit 0 quat_ok, bit 1 gyro_ok
//   bytes 1..8   quaternion w, x, y, z, high byte first
//   bytes 9..14  gyro x, y, z, high byte first
// All pins are sampled by clk, so sclk must stay slow against clk
module spi_sensor_slave (
    input  logic              clk,
    input  logic              rst_n,
    input  sensor_pkg::quat_t quat,
    input  logic              quat_ok,
    input  sensor_pkg::gyro_t gyro,
    input  logic              gyro_ok,
    input  logic              sclk,
    input  logic              cs_n,
    output logic              miso
);

    localparam int FRAME_BITS = `SENSOR_FRAME_BYTES * 8;

    // Two-flop synchronizers for the SPI pins
    logic [1:0]            sclk_ff;
    logic [1:0]            cs_n_ff;
    logic                  sclk_sync;
    logic                  cs_n_sync;
    // Synchronized values one clk earlier, for edge detection
    logic                  sclk_last;
    logic                  cs_n_last;
    logic                  cs_fall;
    logic                  sclk_fall;
    logic [7:0]            status;
    logic [FRAME_BITS-1:0] frame;
    logic [FRAME_BITS-1:0] shreg;

    // Pins idle with cs_n high and sclk low in mode 0
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sclk_ff   <= 2'b00;
            cs_n_ff   <= 2'b11;
            sclk_last <= 1'b0;
            cs_n_last <= 1'b1;
        end else begin
            sclk_ff   <= {sclk_ff[0], sclk};
            cs_n_ff   <= {cs_n_ff[0], cs_n};
            sclk_last <= sclk_sync;
            cs_n_last <= cs_n_sync;
        end
    end

    assign sclk_sync = sclk_ff[1];
    assign cs_n_sync = cs_n_ff[1];

    // Edges of the synchronized pins
    // Each acts on the third clk edge after the pin moved
    assign cs_fall   = cs_n_last & ~cs_n_sync;
    assign sclk_fall = sclk_last & ~sclk_sync;

    assign status = {6'b000000, gyro_ok, quat_ok};

    // Frame image in transmit order, first bit in the top position
    assign frame = {status,
                    quat.w, quat.x, quat.y, quat.z,
                    gyro.x, gyro.y, gyro.z};

    // Loading on cs_n fall is the snapshot
    // Readings latched later wait for the next frame
    always_ff @(posedge clk) begin
        if (cs_n_sync) begin
            // Deselected, so nothing stale is left for the next frame
            shreg <= '0;
        end else if (cs_fall) begin
            shreg <= frame;
        end else if (sclk_fall) begin
            // The master sampled the current bit on the rising edge, move to the next
            // Zeros follow once the 15 bytes are out
            shreg <= {shreg[FRAME_BITS-2:0], 1'b0};
        end
    end

    // Output driven low whenever the slave is not selected
    assign miso = cs_n_sync ? 1'b0 : shreg[FRAME_BITS-1];

endmodule

`default_nettype wire

// File: sensor_report_parser.sv
`default_nettype none
`include "sensor_defs.svh"

// Byte-serial decoder for input reports on the sensor-hub link
// Packet bytes by position
//   0..3   transport header: length LSB, length MSB, channel, sequence
//   4..7   report header: report ID, sequence, status, delay
//   8..    little-endian 16-bit values
// Rotation vector carries x, y, z, w in bytes 8..15, gyro carries x, y, z in bytes 8..13
module sensor_report_parser (
    input  logic                   clk,
    input  logic                   rst_n,
    input  sensor_pkg::shtp_byte_t rx,
    input  logic                   rx_valid,
    output sensor_pkg::quat_t      quat_raw,
    output logic                   quat_done,
    output sensor_pkg::gyro_t      gyro_raw,
    output logic                   gyro_done
);

    // What the parser does with the rest of the current packet
    // MODE_SKIP is also the idle state until the first sop after reset
    typedef enum logic [1:0] {
        MODE_SKIP,
        MODE_HEADER,
        MODE_ROT,
        MODE_GYRO
    } parse_mode_t;

    parse_mode_t mode;
    parse_mode_t cur_mode;
    parse_mode_t next_mode;
    // Position that the next accepted byte will have in its packet
    logic [4:0]  byte_idx;
    logic [4:0]  cur_idx;
    logic        in_data;
    logic [3:0]  lane;

    // A sop byte is always position 0 of a fresh packet, whatever came before
    assign cur_idx  = rx.sop ? 5'd0 : byte_idx;
    assign cur_mode = rx.sop ? MODE_HEADER : mode;

    // Bytes 8 to 15 hold the 16-bit values
    // Anything from byte 16 on (accuracy fields) falls outside
    assign in_data = (cur_idx[4:3] == 2'b01);

    // Even positions carry the low byte, odd positions the high byte
    assign lane = {cur_idx[0], 3'b000};

    // Packet classification from the channel and report ID bytes
    always_comb begin
        next_mode = cur_mode;
        case (cur_mode)
            MODE_HEADER: begin
                if (cur_idx == 5'd2) begin
                    if (rx.data != `SHTP_CHANNEL_INPUT) begin
                        next_mode = MODE_SKIP;
                    end
                end else if (cur_idx == 5'd4) begin
                    case (rx.data)
                        `SENSOR_REPORT_ROTATION: next_mode = MODE_ROT;
                        `SENSOR_REPORT_GYRO:     next_mode = MODE_GYRO;
                        default:                 next_mode = MODE_SKIP;
                    endcase
                end
            end
            MODE_ROT: begin
                // Trailing accuracy bytes after w are of no interest
                if (cur_idx == 5'd15) begin
                    next_mode = MODE_SKIP;
                end
            end
            MODE_GYRO: begin
                if (cur_idx == 5'd13) begin
                    next_mode = MODE_SKIP;
                end
            end
            default: next_mode = MODE_SKIP;
        endcase
    end

    // Position counter, packet mode and the completion pulses
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode      <= MODE_SKIP;
            byte_idx  <= '0;
            quat_done <= 1'b0;
            gyro_done <= 1'b0;
        end else begin
            // The pulse shows in the cycle after the final byte, together with its field
            quat_done <= rx_valid && (cur_mode == MODE_ROT) && (cur_idx == 5'd15);
            gyro_done <= rx_valid && (cur_mode == MODE_GYRO) && (cur_idx == 5'd13);
            if (rx_valid) begin
                mode <= next_mode;
                // Saturate so that long packets never wrap back into the header
                byte_idx <= (cur_idx == 5'd31) ? cur_idx : cur_idx + 5'd1;
            end
        end
    end

    // Field updates, one byte lane at a time
    // Outputs therefore hold a mix of old and new values until the done pulse
    always_ff @(posedge clk) begin
        if (rx_valid && in_data) begin
            if (cur_mode == MODE_ROT) begin
                case (cur_idx[2:1])
                    2'd0:    quat_raw.x[lane +: 8] <= rx.data;
                    2'd1:    quat_raw.y[lane +: 8] <= rx.data;
                    2'd2:    quat_raw.z[lane +: 8] <= rx.data;
                    default: quat_raw.w[lane +: 8] <= rx.data;
                endcase
            end else if (cur_mode == MODE_GYRO) begin
                case (cur_idx[2:1])
                    2'd0: gyro_raw.x[lane +: 8] <= rx.data;
                    2'd1: gyro_raw.y[lane +: 8] <= rx.data;
                    2'd2: gyro_raw.z[lane +: 8] <= rx.data;
                    // Gyro report carries no fourth value
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: sensor_packet_builder.sv
`default_nettype none

// Holding register for one complete sensor reading
// The parser writes its fields piecemeal, so consumers read only this copy
// One instance per payload type, selected by payload_t
module sensor_packet_builder #(
    parameter type payload_t = logic [15:0]
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     capture,
    input  payload_t din,
    output payload_t dout,
    output logic     held
);

    // Every field of din is taken on the same edge
    // dout never shows part of one reading and part of the next
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dout <= '0;
        end else if (capture) begin
            dout <= din;
        end
    end

    // Sticky flag, set by the first capture after reset
    // A reader checks it to tell a real zero reading from no reading yet
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            held <= 1'b0;
        end else if (capture) begin
            held <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: sensor_pkg.sv
`default_nettype none

// Shared types of the IMU to SPI bridge
package sensor_pkg;

    // One byte of the host link as it enters the parser
    // The sop flag is set only on the first byte of a packet
    typedef struct packed {
        logic       sop;
        logic [7:0] data;
    } shtp_byte_t;

    // Quaternion reading in the raw fixed-point units of the IMU
    // Member order puts w in the top bits, matching the frame order
    typedef struct packed {
        logic signed [15:0] w;
        logic signed [15:0] x;
        logic signed [15:0] y;
        logic signed [15:0] z;
    } quat_t;

    // Angular rate on the three axes, raw fixed-point units
    typedef struct packed {
        logic signed [15:0] x;
        logic signed [15:0] y;
        logic signed [15:0] z;
    } gyro_t;

endpackage

`default_nettype wire

// File: sensor_defs.svh
`ifndef SENSOR_DEFS_SVH
`define SENSOR_DEFS_SVH

// Constants of the sensor-hub transport and of the SPI read frame

// Report IDs carried in the first byte of an input report
// Calibrated gyroscope report
`define SENSOR_REPORT_GYRO      8'h02
// Rotation vector report, a unit quaternion
`define SENSOR_REPORT_ROTATION  8'h05

// Transport channel that carries sensor input reports
// Every other channel is skipped by the parser
`define SHTP_CHANNEL_INPUT      8'd3

// Length of the SPI read frame in bytes
// One status byte, eight quaternion bytes and six gyro bytes
`define SENSOR_FRAME_BYTES      15

`endif
